/* Bender.yml */
package:
  name: snd_subsystem

sources:
  # design
  - files:
      - common/snd_pkg.sv
      - rtl/tone_gen.sv
      - pcm/pcm_player.sv
      - mixer/snd_mixer.sv
      - rtl/snd_top.sv

  # testbench
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/snd_tb.sv

/* common/snd_pkg.sv */
/*
 * sound subsystem shared definitions
 * register map, bus widths, mixer gains and saturation bounds
 */
package snd_pkg;

    // bus widths
    localparam int reg_aw = 4;      // host register address
    localparam int pcm_aw = 19;     // sample ROM address
    localparam int snd_w  = 16;     // signed audio sample
    localparam int mix_w  = 26;     // mixer accumulator

    // tone voice registers
    localparam logic [reg_aw-1:0] reg_tone_per_l_lo = 4'd0;
    localparam logic [reg_aw-1:0] reg_tone_per_l_hi = 4'd1;
    localparam logic [reg_aw-1:0] reg_tone_per_r_lo = 4'd2;
    localparam logic [reg_aw-1:0] reg_tone_per_r_hi = 4'd3;
    localparam logic [reg_aw-1:0] reg_tone_amp_l    = 4'd4;
    localparam logic [reg_aw-1:0] reg_tone_amp_r    = 4'd5;

    // PCM player registers, address bytes are little endian
    localparam logic [reg_aw-1:0] reg_pcm_start0 = 4'd8;
    localparam logic [reg_aw-1:0] reg_pcm_start1 = 4'd9;
    localparam logic [reg_aw-1:0] reg_pcm_start2 = 4'd10;
    localparam logic [reg_aw-1:0] reg_pcm_end0   = 4'd11;
    localparam logic [reg_aw-1:0] reg_pcm_end1   = 4'd12;
    localparam logic [reg_aw-1:0] reg_pcm_end2   = 4'd13;
    localparam logic [reg_aw-1:0] reg_pcm_ctrl   = 4'd14;

    // bits of the PCM control byte
    localparam int ctrl_play  = 0;
    localparam int ctrl_loop  = 1;
    localparam int ctrl_pan_r = 2;
    localparam int ctrl_pan_l = 3;

    // gains in 4.4 fixed point, 8'h10 is unity
    localparam logic [7:0] fm_gain = 8'h08;

    // indexed by fxlevel, entry 0 is the quietest
    localparam logic [3:0][7:0] pcm_gain_tbl = {
        8'h14,
        8'h08,
        8'h04,
        8'h02
    };

    // output saturation
    localparam logic signed [snd_w-1:0] snd_max = 16'sh7fff;
    localparam logic signed [snd_w-1:0] snd_min = -16'sh8000;

endpackage

/* mixer/snd_mixer.sv */
/*
 * stereo mixer
 * weighs the PCM and tone sources with 4.4 gains, sums them,
 * clips to 16 bits and flags samples that clipped
 */
`timescale 1ns/1ns

module snd_mixer(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             valid,
    input  logic                             pcm_valid,
    input  logic signed [snd_pkg::snd_w-1:0] ch0,       // pcm left
    input  logic signed [snd_pkg::snd_w-1:0] ch1,       // tone left
    input  logic signed [snd_pkg::snd_w-1:0] ch2,       // pcm right
    input  logic signed [snd_pkg::snd_w-1:0] ch3,       // tone right
    input  logic [7:0]                       gain_pcm,
    input  logic [7:0]                       gain_tone,
    output logic signed [snd_pkg::snd_w-1:0] snd_left,
    output logic signed [snd_pkg::snd_w-1:0] snd_right,
    output logic                             sample,
    output logic                             peak
);

    logic signed [snd_pkg::mix_w-1:0] sum_l, sum_r;
    logic signed [snd_pkg::snd_w-1:0] sat_l, sat_r;
    logic                             clip_l, clip_r;

    // gain is unsigned, keep it positive when widened
    function automatic logic signed [snd_pkg::mix_w-1:0] weigh(
        input logic signed [snd_pkg::snd_w-1:0] x,
        input logic [7:0]                       g
    );
        weigh = x * $signed({1'b0, g});
    endfunction

    // MSB of the result is the clip flag
    function automatic logic [snd_pkg::snd_w:0] saturate(
        input logic signed [snd_pkg::mix_w-1:0] v
    );
        if (v > snd_pkg::snd_max)
            saturate = {1'b1, snd_pkg::snd_max};
        else if (v < snd_pkg::snd_min)
            saturate = {1'b1, snd_pkg::snd_min};
        else
            saturate = {1'b0, v[snd_pkg::snd_w-1:0]};
    endfunction

    always_comb begin
        sum_l = (weigh(ch0, gain_pcm) + weigh(ch1, gain_tone)) >>> 4;   // drop 4.4 fraction
        sum_r = (weigh(ch2, gain_pcm) + weigh(ch3, gain_tone)) >>> 4;
        {clip_l, sat_l} = saturate(sum_l);
        {clip_r, sat_r} = saturate(sum_r);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_left  <= '0;
            snd_right <= '0;
            sample    <= 1'b0;
            peak      <= 1'b0;
        end else begin
            sample <= valid;
            if (valid) begin
                snd_left  <= sat_l;
                snd_right <= sat_r;
                peak      <= clip_l | clip_r;     // held for the whole sample
            end
        end
    end

    // both sources must be sampled on the same sample_cen
    a_sources_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid |-> pcm_valid
    );

endmodule

/* pcm/pcm_player.sv */
/*
 * PCM sample player
 * walks the sample ROM from start to end one byte per output sample,
 * keeps one byte prefetched and pans it to either side
 */
`timescale 1ns/1ns

module pcm_player(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             sample_cen,
    input  logic                             wr,
    input  logic [snd_pkg::reg_aw-1:0]       addr,
    input  logic [7:0]                       din,
    input  logic [7:0]                       rom_data,
    input  logic                             rom_ok,
    output logic [snd_pkg::pcm_aw-1:0]       rom_addr,
    output logic                             rom_cs,
    output logic signed [snd_pkg::snd_w-1:0] pcm_left,
    output logic signed [snd_pkg::snd_w-1:0] pcm_right,
    output logic                             pcm_valid
);

    logic [snd_pkg::pcm_aw-1:0] start_addr, end_addr, ptr;
    logic                       loop_en, pan_l, pan_r;
    logic                       playing;
    logic [7:0]                 buf_data;               // prefetched byte
    logic                       buf_ok;                 // buf_data belongs to ptr
    logic                       stale;                  // in-flight fetch no longer wanted
    logic                       ctrl_wr, fetch_done;
    logic [snd_pkg::snd_w-1:0]  sample_val;

    assign ctrl_wr    = wr && addr == snd_pkg::reg_pcm_ctrl;
    assign fetch_done = rom_cs && rom_ok;
    assign sample_val = {buf_data, 8'h00};              // s8 scaled to full range

    // start and end addresses
    always_ff @(posedge clk) begin
        if (wr) begin
            case (addr)
                snd_pkg::reg_pcm_start0: start_addr[7:0]  <= din;
                snd_pkg::reg_pcm_start1: start_addr[15:8] <= din;
                snd_pkg::reg_pcm_start2:
                    start_addr[snd_pkg::pcm_aw-1:16] <= din[snd_pkg::pcm_aw-17:0];
                snd_pkg::reg_pcm_end0:   end_addr[7:0]    <= din;
                snd_pkg::reg_pcm_end1:   end_addr[15:8]   <= din;
                snd_pkg::reg_pcm_end2:
                    end_addr[snd_pkg::pcm_aw-1:16] <= din[snd_pkg::pcm_aw-17:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loop_en <= 1'b0;
            pan_l   <= 1'b0;
            pan_r   <= 1'b0;
        end else if (ctrl_wr) begin
            loop_en <= din[snd_pkg::ctrl_loop];
            pan_l   <= din[snd_pkg::ctrl_pan_l];
            pan_r   <= din[snd_pkg::ctrl_pan_r];
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done && !stale)
            buf_data <= rom_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            playing   <= 1'b0;
            ptr       <= '0;
            buf_ok    <= 1'b0;
            stale     <= 1'b0;
            rom_cs    <= 1'b0;
            rom_addr  <= '0;
            pcm_left  <= '0;
            pcm_right <= '0;
            pcm_valid <= 1'b0;
        end else begin
            pcm_valid <= sample_cen;
            // ROM side
            if (fetch_done) begin
                rom_cs <= 1'b0;
                stale  <= 1'b0;
                if (!stale)
                    buf_ok <= 1'b1;
            end else if (playing && !buf_ok && !rom_cs && !ctrl_wr) begin
                rom_cs   <= 1'b1;
                rom_addr <= ptr;
            end
            // output side
            if (sample_cen) begin
                if (!playing) begin
                    pcm_left  <= '0;
                    pcm_right <= '0;
                end else if (buf_ok) begin
                    pcm_left  <= pan_l ? sample_val : '0;
                    pcm_right <= pan_r ? sample_val : '0;
                    buf_ok    <= 1'b0;
                    if (ptr != end_addr)
                        ptr <= ptr + 1'b1;
                    else if (loop_en)
                        ptr <= start_addr;
                    else
                        playing <= 1'b0;            // last byte out, stop here
                end
                // fetch late, previous sample is repeated
            end
            // a ctrl write restarts or stops playback
            if (ctrl_wr) begin
                playing <= din[snd_pkg::ctrl_play];
                ptr     <= start_addr;
                buf_ok  <= 1'b0;
                stale   <= rom_cs && !rom_ok;       // drop data of any fetch in flight
            end
        end
    end

    a_rom_addr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr)
    );

    // after a stop the only fetch allowed is one already in flight
    a_cs_stopped: assert property (
        @(posedge clk) disable iff (!rst_n)
        rom_cs |-> playing || stale
    );

endmodule

/* rtl/snd_top.sv */
/*
 * sound subsystem top
 * tone voice and PCM player mixed to stereo, with the gains
 * picked from the board option inputs
 */
`timescale 1ns/1ns

module snd_top(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             sample_cen,
    input  logic                             wr,
    input  logic [snd_pkg::reg_aw-1:0]       addr,
    input  logic [7:0]                       din,
    input  logic [1:0]                       fxlevel,
    input  logic                             enable_fm,
    input  logic                             enable_pcm,
    input  logic [7:0]                       rom_data,
    input  logic                             rom_ok,
    output logic [snd_pkg::pcm_aw-1:0]       rom_addr,
    output logic                             rom_cs,
    output logic signed [snd_pkg::snd_w-1:0] snd_left,
    output logic signed [snd_pkg::snd_w-1:0] snd_right,
    output logic                             sample,
    output logic                             peak
);

    logic signed [snd_pkg::snd_w-1:0] tone_left, tone_right;
    logic signed [snd_pkg::snd_w-1:0] pcm_left, pcm_right;
    logic                             tone_valid, pcm_valid;
    logic [7:0]                       pcm_gain, tone_gain;

    // option inputs come from the OSD, register them once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm_gain  <= 8'h00;
            tone_gain <= 8'h00;
        end else begin
            pcm_gain  <= enable_pcm ? snd_pkg::pcm_gain_tbl[fxlevel] : 8'h00;
            tone_gain <= enable_fm ? snd_pkg::fm_gain : 8'h00;
        end
    end

    tone_gen u_tone (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .sample_cen ( sample_cen ),
        .wr         ( wr         ),
        .addr       ( addr       ),
        .din        ( din        ),
        .tone_left  ( tone_left  ),
        .tone_right ( tone_right ),
        .tone_valid ( tone_valid )
    );

    pcm_player u_pcm (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .sample_cen ( sample_cen ),
        .wr         ( wr         ),
        .addr       ( addr       ),
        .din        ( din        ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .rom_addr   ( rom_addr   ),
        .rom_cs     ( rom_cs     ),
        .pcm_left   ( pcm_left   ),
        .pcm_right  ( pcm_right  ),
        .pcm_valid  ( pcm_valid  )
    );

    snd_mixer u_mixer (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .valid      ( tone_valid ),
        .pcm_valid  ( pcm_valid  ),
        .ch0        ( pcm_left   ),
        .ch1        ( tone_left  ),
        .ch2        ( pcm_right  ),
        .ch3        ( tone_right ),
        .gain_pcm   ( pcm_gain   ),
        .gain_tone  ( tone_gain  ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .sample     ( sample     ),
        .peak       ( peak       )
    );

endmodule

/* rtl/tone_gen.sv */
/*
 * tone voice
 * two square-wave channels, each a 16-bit phase accumulator
 * stepped once per output sample, the MSB picks the polarity
 */
`timescale 1ns/1ns

module tone_gen(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             sample_cen,
    input  logic                             wr,
    input  logic [snd_pkg::reg_aw-1:0]       addr,
    input  logic [7:0]                       din,
    output logic signed [snd_pkg::snd_w-1:0] tone_left,
    output logic signed [snd_pkg::snd_w-1:0] tone_right,
    output logic                             tone_valid
);

    logic [1:0][15:0]               per;        // index 0 left, 1 right
    logic [1:0][7:0]                amp;
    logic [1:0][15:0]               phase;
    logic [1:0][15:0]               phase_nx;
    logic [1:0][snd_pkg::snd_w-1:0] level;

    // host writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            per <= '0;
            amp <= '0;
        end else if (wr) begin
            case (addr)
                snd_pkg::reg_tone_per_l_lo: per[0][7:0]  <= din;
                snd_pkg::reg_tone_per_l_hi: per[0][15:8] <= din;
                snd_pkg::reg_tone_per_r_lo: per[1][7:0]  <= din;
                snd_pkg::reg_tone_per_r_hi: per[1][15:8] <= din;
                snd_pkg::reg_tone_amp_l:    amp[0]       <= din;
                snd_pkg::reg_tone_amp_r:    amp[1]       <= din;
                default: ;                  // PCM range, not ours
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            phase_nx[i] = phase[i] + per[i];
            if (per[i] == 16'd0)
                level[i] = '0;                          // muted channel
            else if (phase_nx[i][15])
                level[i] = {amp[i], 8'h00};             // upper half cycle
            else
                level[i] = -{amp[i], 8'h00};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= '0;
            tone_left  <= '0;
            tone_right <= '0;
            tone_valid <= 1'b0;
        end else begin
            tone_valid <= sample_cen;
            if (sample_cen) begin
                phase      <= phase_nx;
                tone_left  <= level[0];
                tone_right <= level[1];
            end
        end
    end

    // output rate is set by sample_cen, back to back strobes mean a broken cen
    a_valid_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        tone_valid |=> !tone_valid
    );

endmodule

/* sim/snd_model.svh */
/*
 * reference model of the sound subsystem
 * register state, tone phases, PCM pointer and mixer arithmetic
 */
`ifndef SND_MODEL_SVH
`define SND_MODEL_SVH

logic [1:0][15:0]            m_per   = '0;      // index 0 left, 1 right
logic [1:0][15:0]            m_phase = '0;
logic [1:0][7:0]             m_amp   = '0;
logic [snd_pkg::pcm_aw-1:0]  m_start = '0;
logic [snd_pkg::pcm_aw-1:0]  m_end   = '0;
logic [snd_pkg::pcm_aw-1:0]  m_ptr   = '0;
logic                        m_loop    = 1'b0;
logic                        m_pan_l   = 1'b0;
logic                        m_pan_r   = 1'b0;
logic                        m_playing = 1'b0;

// expected outputs, one entry per sample_cen
logic signed [snd_pkg::snd_w-1:0] exp_l[$];
logic signed [snd_pkg::snd_w-1:0] exp_r[$];
logic                             exp_peak[$];

task automatic track_write(input logic [snd_pkg::reg_aw-1:0] a, input logic [7:0] d);
    case (a)
        snd_pkg::reg_tone_per_l_lo: m_per[0][7:0]  = d;
        snd_pkg::reg_tone_per_l_hi: m_per[0][15:8] = d;
        snd_pkg::reg_tone_per_r_lo: m_per[1][7:0]  = d;
        snd_pkg::reg_tone_per_r_hi: m_per[1][15:8] = d;
        snd_pkg::reg_tone_amp_l:    m_amp[0]       = d;
        snd_pkg::reg_tone_amp_r:    m_amp[1]       = d;
        snd_pkg::reg_pcm_start0:    m_start[7:0]   = d;
        snd_pkg::reg_pcm_start1:    m_start[15:8]  = d;
        snd_pkg::reg_pcm_start2:    m_start[18:16] = d[2:0];
        snd_pkg::reg_pcm_end0:      m_end[7:0]     = d;
        snd_pkg::reg_pcm_end1:      m_end[15:8]    = d;
        snd_pkg::reg_pcm_end2:      m_end[18:16]   = d[2:0];
        snd_pkg::reg_pcm_ctrl: begin
            m_playing = d[snd_pkg::ctrl_play];
            m_loop    = d[snd_pkg::ctrl_loop];
            m_pan_l   = d[snd_pkg::ctrl_pan_l];
            m_pan_r   = d[snd_pkg::ctrl_pan_r];
            m_ptr     = m_start;                    // playback restarts at start
        end
        default: ;
    endcase
endtask

// one output sample, called when sample_cen is driven
task automatic predict_sample();
    logic signed [15:0] tone[2];
    logic signed [15:0] pcm[2];
    logic signed [15:0] out[2];
    logic signed [15:0] lvl;
    int                 gp, gt, s;
    logic               clip;
    for (int i = 0; i < 2; i++) begin
        m_phase[i] += m_per[i];
        lvl = m_amp[i] * 256;                       // wraps to 16 bits like the port
        tone[i] = (m_per[i] == 16'd0) ? 16'sd0 : m_phase[i][15] ? lvl : -lvl;
    end
    pcm[0] = 16'sd0;
    pcm[1] = 16'sd0;
    if (m_playing) begin
        lvl    = {rom_byte(m_ptr), 8'h00};
        pcm[0] = m_pan_l ? lvl : 16'sd0;
        pcm[1] = m_pan_r ? lvl : 16'sd0;
        if (m_ptr != m_end)
            m_ptr++;
        else if (m_loop)
            m_ptr = m_start;
        else
            m_playing = 1'b0;
    end
    gp   = enable_pcm ? int'(snd_pkg::pcm_gain_tbl[fxlevel]) : 0;
    gt   = enable_fm ? int'(snd_pkg::fm_gain) : 0;
    clip = 1'b0;
    for (int i = 0; i < 2; i++) begin
        s = (pcm[i] * gp + tone[i] * gt) >>> 4;     // 4.4 gains
        if (s > snd_pkg::snd_max) begin
            out[i] = snd_pkg::snd_max;
            clip   = 1'b1;
        end else if (s < snd_pkg::snd_min) begin
            out[i] = snd_pkg::snd_min;
            clip   = 1'b1;
        end else
            out[i] = s[15:0];
    end
    exp_l.push_back(out[0]);
    exp_r.push_back(out[1]);
    exp_peak.push_back(clip);
endtask

`endif

/* sim/snd_tb.sv */
/*
 * testbench for the sound subsystem
 * random register programming checked against a reference model,
 * sample ROM answering after a random delay
 */
`timescale 1ns/1ns

module snd_tb;

    localparam int  max_frames = 300;           // sample_cen pulses the run may take
    localparam int  frame_len  = 32;
    localparam time clk_period = 20;

    logic                             clk, rst_n, sample_cen, wr;
    logic [snd_pkg::reg_aw-1:0]       addr;
    logic [7:0]                       din;
    logic [1:0]                       fxlevel;
    logic                             enable_fm, enable_pcm;
    logic [7:0]                       rom_data = '0;
    logic                             rom_ok   = 1'b0;
    logic [snd_pkg::pcm_aw-1:0]       rom_addr;
    logic                             rom_cs, sample, peak;
    logic signed [snd_pkg::snd_w-1:0] snd_left, snd_right;

    logic [31:0] stim_state  = 32'hf108;
    logic [31:0] delay_state = 32'hf108;        // ROM latency has its own stream
    int          frame_cyc   = frame_len - 1;
    int          rom_wait    = 0;
    logic        rom_busy    = 1'b0;
    logic        cen_q1      = 1'b0;
    logic        cen_q2      = 1'b0;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = xorshift(stim_state);
        return stim_state;
    endfunction

    // ROM contents, hash of the whole address
    function automatic logic [7:0] rom_byte(input logic [snd_pkg::pcm_aw-1:0] a);
        logic [31:0] h;
        h = xorshift({13'h1b5, a});
        return h[15:8] ^ h[7:0];
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

`include "snd_model.svh"

    task automatic check_sample(
        input logic signed [snd_pkg::snd_w-1:0] got_l,
        input logic signed [snd_pkg::snd_w-1:0] got_r,
        input logic                             got_peak
    );
        logic signed [snd_pkg::snd_w-1:0] want_l, want_r;
        logic                             want_peak;
        if (exp_l.size() == 0) begin
            stop_run("sample pulse came with no sample expected by the model");
        end else begin
            want_l    = exp_l.pop_front();
            want_r    = exp_r.pop_front();
            want_peak = exp_peak.pop_front();
            if (got_l !== want_l || got_r !== want_r || got_peak !== want_peak)
                stop_run($sformatf("Error at %0t: out %0d/%0d peak %b, expected %0d/%0d peak %b",
                    $time, got_l, got_r, got_peak, want_l, want_r, want_peak));
        end
    endtask

    task automatic check_rom(input logic [snd_pkg::pcm_aw-1:0] got);
        if (!m_playing)
            stop_run("sample ROM was read while playback was stopped");
        else if (got !== m_ptr)
            stop_run($sformatf("Error at %0t: rom_addr %h, expected %h", $time, got, m_ptr));
    endtask

    snd_top snd_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(clk_period * (max_frames * frame_len + 200));
        stop_run("timeout: the run went on past its expected length");
    end

    // sample ROM, one request at a time
    always @(posedge clk) begin
        if (!rst_n) begin
            rom_ok   <= 1'b0;
            rom_busy = 1'b0;
        end else if (rom_ok) begin
            rom_ok   <= 1'b0;                   // transfer taken on this edge
            rom_busy = 1'b0;
        end else if (rom_cs) begin
            if (!rom_busy) begin
                check_rom(rom_addr);
                delay_state = xorshift(delay_state);
                rom_wait    = delay_state % 8;  // 1 to 8 cycles
                rom_busy    = 1'b1;
            end
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_byte(rom_addr);
            end else
                rom_wait--;
        end
    end

    // sample must follow sample_cen by exactly two cycles
    always @(posedge clk) begin
        if (rst_n) begin
            if (sample !== cen_q2)
                stop_run($sformatf("Error at %0t: sample %b, sample_cen two cycles back %b",
                    $time, sample, cen_q2));
            else if (sample)
                check_sample(snd_left, snd_right, peak);
            cen_q2 = cen_q1;
            cen_q1 = sample_cen;
        end
    end

    task automatic tick();
        @(posedge clk);
        frame_cyc++;
        wr         <= 1'b0;
        sample_cen <= 1'b0;
    endtask

    task automatic write_reg(input logic [snd_pkg::reg_aw-1:0] a, input logic [7:0] d);
        tick();
        wr   <= 1'b1;
        addr <= a;
        din  <= d;
        track_write(a, d);
    endtask

    task automatic set_options(input logic fm, input logic pcm, input logic [1:0] lvl);
        tick();
        enable_fm  <= fm;
        enable_pcm <= pcm;
        fxlevel    <= lvl;
    endtask

    task automatic pulse_sample();
        while (frame_cyc < frame_len - 1)
            tick();
        tick();
        sample_cen <= 1'b1;
        frame_cyc = 0;
        predict_sample();
        repeat (12) tick();                     // prefetch done before any write
    endtask

    task automatic program_pcm(input logic loop_en, input logic [1:0] pan);
        logic [31:0]                r;
        logic [snd_pkg::pcm_aw-1:0] first, last;
        logic [7:0]                 ctrl;
        r     = next_rand();
        first = {1'b0, r[17:0]};
        last  = first + 2 + r[31:29];           // 3 to 10 bytes
        ctrl  = 8'h00;
        ctrl[snd_pkg::ctrl_play]  = 1'b1;
        ctrl[snd_pkg::ctrl_loop]  = loop_en;
        ctrl[snd_pkg::ctrl_pan_l] = pan[1];
        ctrl[snd_pkg::ctrl_pan_r] = pan[0];
        write_reg(snd_pkg::reg_pcm_start0, first[7:0]);
        write_reg(snd_pkg::reg_pcm_start1, first[15:8]);
        write_reg(snd_pkg::reg_pcm_start2, 8'(first[18:16]));
        write_reg(snd_pkg::reg_pcm_end0, last[7:0]);
        write_reg(snd_pkg::reg_pcm_end1, last[15:8]);
        write_reg(snd_pkg::reg_pcm_end2, 8'(last[18:16]));
        write_reg(snd_pkg::reg_pcm_ctrl, ctrl);
    endtask

    task automatic program_tone(
        input logic [7:0] amp_l,
        input logic [7:0] amp_r,
        input logic       mute_l
    );
        logic [31:0] r;
        r = next_rand();
        if (mute_l)
            r[31:16] = 16'd0;                   // muted left channel
        write_reg(snd_pkg::reg_tone_per_l_lo, r[23:16]);
        write_reg(snd_pkg::reg_tone_per_l_hi, r[31:24]);
        write_reg(snd_pkg::reg_tone_per_r_lo, r[7:0]);
        write_reg(snd_pkg::reg_tone_per_r_hi, r[15:8]);
        write_reg(snd_pkg::reg_tone_amp_l, amp_l);
        write_reg(snd_pkg::reg_tone_amp_r, amp_r);
    endtask

    initial begin
        logic [31:0] r;
        rst_n      = 1'b0;
        sample_cen = 1'b0;
        wr         = 1'b0;
        addr       = '0;
        din        = '0;
        fxlevel    = '0;
        enable_fm  = 1'b0;
        enable_pcm = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        tick();
        if (snd_left !== '0 || snd_right !== '0 || peak !== 1'b0 || rom_cs !== 1'b0)
            stop_run($sformatf("Error at %0t: outputs not cleared by reset", $time));
        // idle after reset, nothing programmed
        set_options(1'b1, 1'b1, 2'd3);
        repeat (8) pulse_sample();
        // tone voice alone
        set_options(1'b1, 1'b0, 2'd0);
        for (int i = 0; i < 6; i++) begin
            r = next_rand();
            program_tone(r[7:0] | 8'h01, r[15:8], i[0]);
            repeat (10) pulse_sample();
        end
        // PCM alone at each fx level
        for (int lvl = 0; lvl < 4; lvl++) begin
            r = next_rand();
            set_options(1'b0, 1'b1, 2'(lvl));
            program_pcm(r[0], r[2:1]);
            repeat (30) pulse_sample();
        end
        // both sources at full level, drives the mixer into clipping
        program_pcm(1'b1, 2'b11);
        program_tone(8'h7f, 8'h7f, 1'b0);
        set_options(1'b1, 1'b1, 2'd3);
        repeat (40) pulse_sample();
        // enables changed between samples
        for (int i = 0; i < 60; i++) begin
            r = next_rand();
            set_options(r[0], r[1], r[3:2]);
            pulse_sample();
        end
        repeat (4) tick();
        if (exp_l.size() != 0) begin
            stop_run("run ended with expected samples that never came out");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* tb.f */
+incdir+sim
common/snd_pkg.sv
rtl/tone_gen.sv
pcm/pcm_player.sv
mixer/snd_mixer.sv
rtl/snd_top.sv
sim/snd_tb.sv
